/* design/memoryGame_params.svh */
// ----------------------------------------
// Memory game sizes and timing constants
// ----------------------------------------
`ifndef MEMORY_GAME_PARAMS_SVH
`define MEMORY_GAME_PARAMS_SVH

// Sequence memory and game length
`define SEQ_DEPTH 16
`define SHORT_ROUNDS 8
`define LONG_ROUNDS 16

// Display timing in clock cycles
`define SHOW_TICKS 8
`define SHOW_HALF 4

// Player response limits in clock cycles
`define TIMEOUT_LONG 64
`define TIMEOUT_SHORT 32

// Preset colours, entry 0 in the low nibble
`define PRESET_SEQ 64'h2814_4182_1824_8241

`endif

/* design/gameDataPkg.sv */
// ----------------------------------------
// Memory game datapath vector types
// ----------------------------------------
package gameDataPkg;

    // One-hot colour for keys, LEDs and memory words
    typedef logic [3:0] keyT;

    // Sequence memory address
    typedef logic [3:0] addressT;

    // Round index, round n shows entries 0 to n
    typedef logic [3:0] roundT;

    // Display and response timer count
    typedef logic [6:0] tickT;

endpackage

/* design/gameStatePkg.sv */
// ----------------------------------------
// Memory game controller state encoding
// ----------------------------------------
package gameStatePkg;

    typedef enum logic [4:0] {
        idle         = 5'd0,
        initElements = 5'd1,
        roundStart   = 5'd2,
        showEntry    = 5'd3,
        waitShow     = 5'd4,
        blankShow    = 5'd5,
        showNext     = 5'd6,
        playStart    = 5'd7,
        waitPlay     = 5'd8,
        storePlay    = 5'd9,
        comparePlay  = 5'd10,
        nextPlay     = 5'd11,
        nextRound    = 5'd12,
        addEntry     = 5'd13,
        waitRecord   = 5'd14,
        recordEntry  = 5'd15,
        showRecord   = 5'd16,
        wonGame      = 5'd17,
        lostGame     = 5'd18,
        timedOutGame = 5'd19
    } controllerState;

endpackage

/* design/gameControlIf.sv */
// ----------------------------------------
// Control strobes and condition flags
// between the FSM and the datapath
// ----------------------------------------
`timescale 1ns/1ps

interface gameControlIf;
    import gameDataPkg::*;

    // Control from the FSM
    logic clearAddress;
    logic countAddress;
    logic clearRound;
    logic countRound;
    logic clearShow;
    logic countShow;
    logic clearResponse;
    logic countResponse;
    logic storeLevels;
    logic clearKey;
    logic storeKey;
    logic writeEntry;

    // Conditions back from the datapath
    logic showMid;
    logic showEnd;
    logic timeUp;
    logic addressAtRound;
    logic lastRound;
    logic playMade;
    logic playCorrect;
    keyT  entry;
    keyT  playedKey;

    modport controller (
        output clearAddress, countAddress, clearRound, countRound,
        output clearShow, countShow, clearResponse, countResponse,
        output storeLevels, clearKey, storeKey, writeEntry,
        input  showMid, showEnd, timeUp, addressAtRound, lastRound,
        input  playMade, playCorrect
    );

    modport datapath (
        input  clearAddress, countAddress, clearRound, countRound,
        input  clearShow, countShow, clearResponse, countResponse,
        input  storeLevels, clearKey, storeKey, writeEntry,
        output showMid, showEnd, timeUp, addressAtRound, lastRound,
        output playMade, playCorrect, entry, playedKey
    );

endinterface

/* design/gameController.sv */
// ----------------------------------------
// Memory game control unit
// Moore FSM for display, play, compare,
// recording and end states
// ----------------------------------------
`timescale 1ns/1ps

module gameController (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         mode2,
    gameControlIf.controller             ctrl,
    output logic                         ledsOn,
    output logic                         echoKey,
    output logic                         won,
    output logic                         lost,
    output logic                         ready,
    output logic                         playerTurn,
    output logic                         newEntry,
    output logic                         timedOut,
    output gameStatePkg::controllerState stateOut
);
    import gameStatePkg::*;

    controllerState state;
    controllerState nextState;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        nextState = state;
        case (state)
            idle:         nextState = start ? initElements : idle;
            initElements: nextState = roundStart;
            roundStart:   nextState = blankShow;
            blankShow:    nextState = ctrl.showMid ? showEntry : blankShow;
            showEntry:    nextState = waitShow;
            waitShow: begin
                if (ctrl.showEnd) begin
                    nextState = ctrl.addressAtRound ? playStart : showNext;
                end
            end
            showNext:     nextState = blankShow;
            playStart:    nextState = waitPlay;
            waitPlay: begin
                // Timeout wins over a key in the same cycle
                if (ctrl.timeUp) begin
                    nextState = timedOutGame;
                end else if (ctrl.playMade) begin
                    nextState = storePlay;
                end
            end
            storePlay:    nextState = comparePlay;
            comparePlay: begin
                // Decide only once the echo is over
                if (ctrl.showMid) begin
                    if (!ctrl.playCorrect) begin
                        nextState = lostGame;
                    end else if (!ctrl.addressAtRound) begin
                        nextState = nextPlay;
                    end else if (ctrl.lastRound) begin
                        nextState = wonGame;
                    end else begin
                        nextState = mode2 ? addEntry : nextRound;
                    end
                end
            end
            nextPlay:     nextState = waitPlay;
            nextRound:    nextState = roundStart;
            addEntry:     nextState = waitRecord;
            waitRecord: begin
                if (ctrl.timeUp) begin
                    nextState = timedOutGame;
                end else if (ctrl.playMade) begin
                    nextState = recordEntry;
                end
            end
            recordEntry:  nextState = showRecord;
            showRecord:   nextState = ctrl.showMid ? roundStart : showRecord;
            wonGame:      nextState = start ? initElements : wonGame;
            lostGame:     nextState = start ? initElements : lostGame;
            timedOutGame: nextState = start ? initElements : timedOutGame;
            default:      nextState = idle;
        endcase
    end

    // ----------------------------------------
    // Moore outputs
    // ----------------------------------------
    assign ctrl.clearAddress  = (state == initElements) || (state == roundStart)
                             || (state == playStart);
    assign ctrl.countAddress  = (state == showNext) || (state == nextPlay)
                             || (state == addEntry);
    assign ctrl.clearRound    = (state == initElements);
    assign ctrl.countRound    = (state == nextRound) || (state == addEntry);
    assign ctrl.clearShow     = (state == roundStart) || (state == storePlay)
                             || (state == recordEntry);
    assign ctrl.countShow     = (state == blankShow) || (state == showEntry)
                             || (state == waitShow) || (state == showNext)
                             || (state == comparePlay) || (state == showRecord);
    assign ctrl.clearResponse = (state == initElements) || (state == playStart)
                             || (state == nextPlay) || (state == addEntry);
    assign ctrl.countResponse = (state == waitPlay) || (state == waitRecord);
    assign ctrl.storeLevels   = (state == initElements);
    assign ctrl.clearKey      = (state == initElements) || (state == roundStart);
    assign ctrl.storeKey      = (state == storePlay) || (state == recordEntry);
    assign ctrl.writeEntry    = (state == showRecord);

    // Stored entry lit, or the player's key echoed
    assign ledsOn     = (state == showEntry) || (state == waitShow);
    assign echoKey    = (state == comparePlay) || (state == showRecord);

    assign won        = (state == wonGame);
    assign lost       = (state == lostGame) || (state == timedOutGame);
    assign timedOut   = (state == timedOutGame);
    assign ready      = (state == wonGame) || (state == lostGame)
                     || (state == timedOutGame);
    assign playerTurn = (state == waitPlay) || (state == waitRecord);
    assign newEntry   = (state == waitRecord);
    assign stateOut   = state;

    // A key press reaches the FSM as a one-cycle strobe
    assert property (@(posedge clock) disable iff (reset)
        ctrl.playMade |=> !ctrl.playMade);

    // The lit phase only ends while an entry is shown
    assert property (@(posedge clock) disable iff (reset)
        ctrl.showEnd |-> (state == waitShow));

endmodule

/* design/sequenceStore.sv */
// ----------------------------------------
// Sequence memory with address and round
// counters and the game length level
// ----------------------------------------
`timescale 1ns/1ps
`include "memoryGame_params.svh"

module sequenceStore (
    input  logic           clock,
    input  logic           reset,
    gameControlIf.datapath ctrl,
    input  logic           levelLength
);
    import gameDataPkg::*;

    localparam logic [4*`SEQ_DEPTH-1:0] presetTable = `PRESET_SEQ;

    keyT     memory [`SEQ_DEPTH];
    addressT addressCount;
    roundT   roundCount;
    logic    lengthLevel;

    // Preset colours come back on every reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `SEQ_DEPTH; i++) begin
                memory[i] <= presetTable[i*4 +: 4];
            end
        end else if (ctrl.writeEntry) begin
            memory[addressCount] <= ctrl.playedKey;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            addressCount <= '0;
            roundCount   <= '0;
            lengthLevel  <= 1'b0;
        end else begin
            if (ctrl.clearAddress) begin
                addressCount <= '0;
            end else if (ctrl.countAddress) begin
                addressCount <= addressCount + addressT'(1);
            end
            if (ctrl.clearRound) begin
                roundCount <= '0;
            end else if (ctrl.countRound) begin
                roundCount <= roundCount + roundT'(1);
            end
            if (ctrl.storeLevels) begin
                lengthLevel <= levelLength;
            end
        end
    end

    assign ctrl.entry          = memory[addressCount];
    assign ctrl.addressAtRound = (addressCount == roundCount);

    // High level plays the long game
    assign ctrl.lastRound = lengthLevel ? (roundCount == roundT'(`LONG_ROUNDS - 1))
                                        : (roundCount == roundT'(`SHORT_ROUNDS - 1));

    // New entries only go on the end of the sequence
    assert property (@(posedge clock) disable iff (reset)
        ctrl.writeEntry |-> (addressCount == roundCount));

endmodule

/* design/gameTimers.sv */
// ----------------------------------------
// Display timer and player response timer
// ----------------------------------------
`timescale 1ns/1ps
`include "memoryGame_params.svh"

module gameTimers (
    input  logic           clock,
    input  logic           reset,
    gameControlIf.datapath ctrl,
    input  logic           levelTime
);
    import gameDataPkg::*;

    // One display period is a blank phase then a lit phase
    localparam tickT showMidCount = tickT'(`SHOW_HALF - 1);
    localparam tickT showEndCount = tickT'(`SHOW_HALF + `SHOW_TICKS - 1);

    tickT showCount;
    tickT responseCount;
    tickT responseLimit;
    logic timeLevel;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            showCount <= '0;
        end else if (ctrl.clearShow) begin
            showCount <= '0;
        end else if (ctrl.countShow) begin
            // Wrap so the next period starts blank
            showCount <= ctrl.showEnd ? tickT'(0) : showCount + tickT'(1);
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            responseCount <= '0;
            timeLevel     <= 1'b0;
        end else begin
            if (ctrl.clearResponse) begin
                responseCount <= '0;
            end else if (ctrl.countResponse) begin
                responseCount <= responseCount + tickT'(1);
            end
            if (ctrl.storeLevels) begin
                timeLevel <= levelTime;
            end
        end
    end

    // High time level gives the short limit
    assign responseLimit = timeLevel ? tickT'(`TIMEOUT_SHORT - 1)
                                     : tickT'(`TIMEOUT_LONG - 1);

    assign ctrl.showMid = (showCount == showMidCount);
    assign ctrl.showEnd = (showCount == showEndCount);
    assign ctrl.timeUp  = (responseCount == responseLimit);

endmodule

/* design/keyCapture.sv */
// ----------------------------------------
// Key press detection, key register and
// compare against the current entry
// ----------------------------------------
`timescale 1ns/1ps

module keyCapture (
    input  logic              clock,
    input  logic              reset,
    input  gameDataPkg::keyT  keys,
    gameControlIf.datapath    ctrl
);
    import gameDataPkg::*;

    keyT  previousKeys;
    keyT  pressedKey;
    keyT  keyRegister;
    logic keyEdge;
    logic playStrobe;

    // Any key down after all keys up
    assign keyEdge = (previousKeys == '0) && (keys != '0);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            previousKeys <= '0;
            playStrobe   <= 1'b0;
            keyRegister  <= '0;
        end else begin
            previousKeys <= keys;
            playStrobe   <= keyEdge;
            if (ctrl.clearKey) begin
                keyRegister <= '0;
            end else if (ctrl.storeKey) begin
                keyRegister <= pressedKey;
            end
        end
    end

    // Holds the press until the FSM stores it
    always_ff @(posedge clock) begin
        if (keyEdge) begin
            pressedKey <= keys;
        end
    end

    assign ctrl.playMade    = playStrobe;
    assign ctrl.playedKey   = keyRegister;
    assign ctrl.playCorrect = (keyRegister == ctrl.entry);

    assert property (@(posedge clock) disable iff (reset) $onehot0(keyRegister));

endmodule

/* design/memoryGame.sv */
// ----------------------------------------
// Memory game top level
// ----------------------------------------
`timescale 1ns/1ps

module memoryGame (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         start,
    input  gameDataPkg::keyT             keys,
    input  logic                         levelTime,
    input  logic                         levelLength,
    input  logic                         mode2,
    output gameDataPkg::keyT             leds,
    output logic                         won,
    output logic                         lost,
    output logic                         ready,
    output logic                         playerTurn,
    output logic                         newEntry,
    output logic                         timedOut,
    output gameStatePkg::controllerState stateOut
);
    logic ledsOn;
    logic echoKey;

    gameControlIf ctrl ();

    gameController controllerInst (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .mode2      (mode2),
        .ctrl       (ctrl),
        .ledsOn     (ledsOn),
        .echoKey    (echoKey),
        .won        (won),
        .lost       (lost),
        .ready      (ready),
        .playerTurn (playerTurn),
        .newEntry   (newEntry),
        .timedOut   (timedOut),
        .stateOut   (stateOut)
    );

    sequenceStore storeInst (
        .clock       (clock),
        .reset       (reset),
        .ctrl        (ctrl),
        .levelLength (levelLength)
    );

    gameTimers timersInst (
        .clock     (clock),
        .reset     (reset),
        .ctrl      (ctrl),
        .levelTime (levelTime)
    );

    keyCapture keyInst (
        .clock (clock),
        .reset (reset),
        .keys  (keys),
        .ctrl  (ctrl)
    );

    // Echo of the played key, else the stored entry while shown
    assign leds = echoKey ? ctrl.playedKey : (ledsOn ? ctrl.entry : '0);

endmodule

/* testbench/memoryGameTb.sv */
// ----------------------------------------
// Memory game testbench, plays scripted
// games and checks shows and outcomes
// ----------------------------------------
`timescale 1ns/1ps
`include "memoryGame_params.svh"

module memoryGameTb;
    import gameDataPkg::*;
    import gameStatePkg::*;

    localparam int outcomeWon     = 0;
    localparam int outcomeLost    = 1;
    localparam int outcomeTimeout = 2;
    localparam int noRound        = -1;
    localparam logic [4*`SEQ_DEPTH-1:0] presetTable = `PRESET_SEQ;

    // One game per row
    typedef struct packed {
        logic levelTime;
        logic levelLength;
        logic mode2;
        int   errorRound;
        int   errorPos;
        int   pauseRound;
        int   pauseCycles;
        int   outcome;
    } scenarioT;

    logic           clock;
    logic           reset;
    logic           start;
    keyT            keys;
    logic           levelTime;
    logic           levelLength;
    logic           mode2;
    keyT            leds;
    logic           won;
    logic           lost;
    logic           ready;
    logic           playerTurn;
    logic           newEntry;
    logic           timedOut;
    controllerState stateOut;

    scenarioT    scenarios[$];
    string       scenarioNames[$];
    keyT         model [`SEQ_DEPTH];
    string       testName;
    int          cycleCount;
    int          cycleLimit;
    logic [31:0] lcgState;

    memoryGame memoryGame_inst (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .keys        (keys),
        .levelTime   (levelTime),
        .levelLength (levelLength),
        .mode2       (mode2),
        .leds        (leds),
        .won         (won),
        .lost        (lost),
        .ready       (ready),
        .playerTurn  (playerTurn),
        .newEntry    (newEntry),
        .timedOut    (timedOut),
        .stateOut    (stateOut)
    );

    always #20 clock = ~clock;

    task automatic failRun(input string text);
        $display("%s", text);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic valueError(input string what, input int expected, input int actual);
        failRun($sformatf("[ERROR] %s: %s expected %0h, actual %0h",
                          testName, what, expected, actual));
    endtask

    // Inputs change and outputs are sampled 2 ns after the edge
    task automatic nextCycle();
        @(posedge clock);
        #2;
        cycleCount++;
        assert (cycleCount < cycleLimit)
            else failRun($sformatf("Timeout: %s did not finish within %0d cycles",
                                   testName, cycleLimit));
    endtask

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic keyT randomKey();
        logic [31:0] value;
        value = nextRandom();
        return keyT'(4'b0001 << value[17:16]);
    endfunction

    // Rotating a one-hot value by 1 to 3 always moves the colour
    function automatic keyT wrongKey(input keyT correct);
        logic [31:0] value;
        int          turn;
        value = nextRandom();
        turn  = 1 + int'(value[17:16]) % 3;
        return (correct << turn) | (correct >> (4 - turn));
    endfunction

    task automatic addScenario(input string name, input logic timeLevel,
                               input logic lengthLevel, input logic modeTwo,
                               input int errorRound, input int errorPos,
                               input int pauseRound, input int pauseCycles,
                               input int outcome);
        scenarios.push_back({timeLevel, lengthLevel, modeTwo, errorRound, errorPos,
                             pauseRound, pauseCycles, outcome});
        scenarioNames.push_back(name);
    endtask

    function automatic int gameBudget(input scenarioT s);
        int rounds;
        rounds = s.levelLength ? `LONG_ROUNDS : `SHORT_ROUNDS;
        return rounds * (`SEQ_DEPTH * (`SHOW_TICKS + `SHOW_HALF) + `SEQ_DEPTH * `TIMEOUT_LONG)
             + s.pauseCycles;
    endfunction

    // LED on-intervals until the player's turn, one per shown entry
    task automatic collectShow(input int round);
        keyT lit;
        int  litCycles;
        int  shown;
        lit       = '0;
        litCycles = 0;
        shown     = 0;
        while (!playerTurn && !ready) begin
            if (leds != '0) begin
                assert (litCycles == 0 || leds == lit)
                    else valueError("steady LED", int'(lit), int'(leds));
                lit = leds;
                litCycles++;
            end else if (litCycles > 0) begin
                assert (litCycles == `SHOW_TICKS)
                    else valueError("LED on-time", `SHOW_TICKS, litCycles);
                assert (shown <= round)
                    else failRun($sformatf("%s: round %0d shows too many entries",
                                           testName, round));
                assert (lit == model[shown])
                    else valueError($sformatf("round %0d entry %0d", round, shown),
                                    int'(model[shown]), int'(lit));
                shown++;
                litCycles = 0;
            end
            nextCycle();
        end
        assert (shown == round + 1)
            else valueError($sformatf("entries shown in round %0d", round), round + 1, shown);
    endtask

    task automatic stayIdle(input int cycles);
        for (int i = 0; i < cycles && !ready; i++) begin
            nextCycle();
        end
    endtask

    // One-cycle press, then wait out the echo
    task automatic pressKey(input keyT key);
        while (!playerTurn && !ready) begin
            nextCycle();
        end
        if (!ready) begin
            keys = key;
            nextCycle();
            keys = '0;
            while (leds == '0) begin
                nextCycle();
            end
            assert (leds == key) else valueError("key echo", int'(key), int'(leds));
            while (leds != '0) begin
                nextCycle();
            end
        end
    endtask

    task automatic recordEntry(input int slot);
        keyT key;
        while (!newEntry && !ready) begin
            nextCycle();
        end
        assert (newEntry)
            else failRun($sformatf("%s: no new entry request after round %0d",
                                   testName, slot - 1));
        key         = randomKey();
        model[slot] = key;
        pressKey(key);
    endtask

    task automatic runGame(input scenarioT s);
        int   rounds;
        int   round;
        int   pos;
        keyT  key;
        logic wrong;
        logic finished;
        rounds      = s.levelLength ? `LONG_ROUNDS : `SHORT_ROUNDS;
        levelTime   = s.levelTime;
        levelLength = s.levelLength;
        mode2       = s.mode2;
        start       = 1'b1;
        nextCycle();
        start       = 1'b0;
        finished    = 1'b0;
        round       = 0;
        while (round < rounds && !finished) begin
            collectShow(round);
            pos = 0;
            while (pos <= round && !finished) begin
                if (round == s.pauseRound && pos == 0) begin
                    stayIdle(s.pauseCycles);
                end
                if (ready) begin
                    finished = 1'b1;
                end else begin
                    wrong = (round == s.errorRound) && (pos == s.errorPos);
                    key   = wrong ? wrongKey(model[pos]) : model[pos];
                    pressKey(key);
                    if (wrong) begin
                        assert (ready && lost)
                            else failRun($sformatf("%s: wrong key did not end the game",
                                                   testName));
                        finished = 1'b1;
                    end
                end
                pos++;
            end
            if (!finished) begin
                if (round == rounds - 1) begin
                    assert (ready && won)
                        else valueError("won after the last round", 1, int'(won));
                end else begin
                    assert (!ready)
                        else failRun($sformatf("%s: game ended after round %0d",
                                               testName, round));
                    if (s.mode2) begin
                        recordEntry(round + 1);
                    end
                end
            end
            round++;
        end
        while (!ready) begin
            nextCycle();
        end
        assert (won == (s.outcome == outcomeWon))
            else valueError("won", int'(s.outcome == outcomeWon), int'(won));
        assert (lost == (s.outcome != outcomeWon))
            else valueError("lost", int'(s.outcome != outcomeWon), int'(lost));
        assert (timedOut == (s.outcome == outcomeTimeout))
            else valueError("timedOut", int'(s.outcome == outcomeTimeout), int'(timedOut));
    endtask

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        start       = 1'b0;
        keys        = '0;
        levelTime   = 1'b0;
        levelLength = 1'b0;
        mode2       = 1'b0;
        lcgState    = 32'h7e3f3186;
        cycleCount  = 0;
        testName    = "reset";
        for (int i = 0; i < `SEQ_DEPTH; i++) begin
            model[i] = presetTable[i*4 +: 4];
        end

        // ----------------------------------------
        // Scenario table
        // ----------------------------------------
        addScenario("shortWin", 0, 0, 0, noRound, 0, noRound, 0, outcomeWon);
        addScenario("longWin", 0, 1, 0, noRound, 0, noRound, 0, outcomeWon);
        addScenario("wrongKey", 0, 0, 0, 3, 2, noRound, 0, outcomeLost);
        addScenario("slowLongLimit", 0, 0, 0, noRound, 0, 2, 40, outcomeWon);
        addScenario("slowShortLimit", 1, 0, 0, noRound, 0, 2, 40, outcomeTimeout);
        addScenario("silent", 0, 0, 0, noRound, 0, 0, 200, outcomeTimeout);
        addScenario("mode2Win", 1, 0, 1, noRound, 0, noRound, 0, outcomeWon);
        addScenario("mode2Wrong", 0, 1, 1, 5, 5, noRound, 0, outcomeLost);

        cycleLimit = 1000;
        foreach (scenarios[i]) begin
            cycleLimit += gameBudget(scenarios[i]);
        end

        repeat (4) begin
            nextCycle();
        end
        reset = 1'b0;
        assert ({won, lost, ready, playerTurn, newEntry, timedOut} == 6'b0)
            else valueError("status after reset", 0,
                            int'({won, lost, ready, playerTurn, newEntry, timedOut}));
        assert (leds == '0) else valueError("leds after reset", 0, int'(leds));
        assert (stateOut == idle) else valueError("state after reset", 0, int'(stateOut));

        foreach (scenarios[i]) begin
            testName = scenarioNames[i];
            runGame(scenarios[i]);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* build.f */
+incdir+design
design/gameDataPkg.sv
design/gameStatePkg.sv
design/gameControlIf.sv
design/gameController.sv
design/sequenceStore.sv
design/gameTimers.sv
design/keyCapture.sv
design/memoryGame.sv
testbench/memoryGameTb.sv

/* Makefile */
# Verilator build and run for the memory game testbench

VERILATOR ?= verilator
TOP       ?= memoryGameTb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
